/* tb.f */
verilog/link_pkg.sv
verilog/credit_sender.sv
verilog/input_fifo.sv
verilog/token_return.sv
verilog/link_kernel.sv
bench/link_kernel_props.sv
bench/link_kernel_tb.sv

/* Makefile */
# Verilator build and run of the link kernel testbench

VERILATOR ?= verilator
TOP       ?= link_kernel_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failures"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '** FAIL **' $(LOG) || \
	   ! grep -qF '** PASS **' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/link_kernel_tb.sv */
/*
  link kernel testbench
  drives the core side of the link channel from a stimulus table,
  keeps a queue model of the word stream and checks ready, valid, data
  and accepted-word counts against the credit and latency rules
*/

`timescale 1ns/1ns

module link_kernel_tb;

  localparam int lg_fifo_depth_lp = link_pkg::lg_fifo_depth_default_c;
  localparam int lg_decimation_lp = link_pkg::lg_decimation_default_c;
  localparam int lg_wait_lp       = link_pkg::lg_wait_after_reset_default_c;
  localparam int fifo_depth_lp    = 2 ** lg_fifo_depth_lp;
  localparam int decimation_lp    = 2 ** lg_decimation_lp;
  localparam int wait_cycles_lp   = 2 ** lg_wait_lp;
  // quota large enough to never run out within a row
  localparam int unlimited_lp     = 100000;
  localparam int drain_limit_lp   = 20000;

  typedef enum int {fill_ph, token_ph, stream_ph, random_ph} phase_t;
  typedef enum int {off_m, always_m, random_m} mode_t;

  typedef struct packed {
    phase_t phase;
    int     send_words;
    int     deq_words;
    mode_t  send_mode;
    mode_t  yumi_mode;
    // expected accepted words, zero leaves the count unchecked
    int     exp_accepts;
  } stim_row_t;

  stim_row_t stim_table [4] = '{
    '{fill_ph,   unlimited_lp, 0,             always_m, off_m,    fifo_depth_lp},
    '{token_ph,  unlimited_lp, decimation_lp, always_m, always_m, decimation_lp},
    '{stream_ph, 40,           unlimited_lp,  always_m, always_m, 0},
    '{random_ph, 300,          unlimited_lp,  random_m, random_m, 0}
  };

  logic                    io_master_clk_i;
  logic                    reset_i;
  logic                    core_valid_i;
  link_pkg::channel_data_t core_data_i;
  logic                    core_ready_o;
  logic                    core_valid_o;
  link_pkg::channel_data_t core_data_o;
  logic                    core_yumi_i;

  // model state
  link_pkg::channel_data_t model_q [$];
  integer seed = 87078;
  mode_t  send_mode = off_m;
  mode_t  yumi_mode = off_m;
  int     send_left = 0;
  int     deq_left = 0;
  int     sent_total = 0;
  int     phase_accepts = 0;
  // buffer occupancy and link register as the rules predict them
  int     occ_model = 0;
  int     inflight = 0;
  int     errors = 0;
  logic   ready_seen = 1'b0;
  logic   checks_on = 1'b0;

  link_kernel #(
    .lg_fifo_depth_p      (lg_fifo_depth_lp),
    .lg_decimation_p      (lg_decimation_lp),
    .lg_wait_after_reset_p(lg_wait_lp)
  ) uut (
    .io_master_clk_i(io_master_clk_i),
    .reset_i        (reset_i),
    .core_valid_i   (core_valid_i),
    .core_data_i    (core_data_i),
    .core_ready_o   (core_ready_o),
    .core_valid_o   (core_valid_o),
    .core_data_o    (core_data_o),
    .core_yumi_i    (core_yumi_i)
  );

  initial begin
    io_master_clk_i = 1'b0;
    forever #5 io_master_clk_i = ~io_master_clk_i;
  end

  // --------------------
  // checks
  // --------------------

  task automatic stop_run();
    errors++;
    $display("** FAIL **");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("FAIL at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_data(input string name, input link_pkg::channel_data_t act,
                            input link_pkg::channel_data_t exp);
    if (act !== exp) begin
      $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input link_pkg::credit_t act,
                             input link_pkg::credit_t exp);
    if (act !== exp) begin
      $display("FAIL at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  // --------------------
  // cycle engine
  // --------------------

  function automatic logic coin();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // odd multiplier keeps words distinct over the run
  function automatic link_pkg::channel_data_t make_word(input int n);
    return link_pkg::channel_data_t'(n * 40503 + 4660);
  endfunction

  task automatic drive_next();
    logic send;
    logic take;
    send = (send_left > 0) && (send_mode == always_m || (send_mode == random_m && coin()));
    // yumi only when the model says a word is presented next cycle
    take = (deq_left > 0) && (occ_model != 0)
        && (yumi_mode == always_m || (yumi_mode == random_m && coin()));
    core_valid_i <= send;
    core_data_i  <= make_word(sent_total);
    core_yumi_i  <= take;
  endtask

  // sample the cycle that just ended, update the model, drive the next
  task automatic step();
    logic acc;
    logic deq;
    @(posedge io_master_clk_i);
    ready_seen = core_ready_o;
    acc = core_valid_i & core_ready_o;
    deq = core_yumi_i;
    if (checks_on) begin
      check_bit("core_valid_o", core_valid_o, occ_model != 0);
    end
    if (deq) begin
      if (model_q.size() == 0) begin
        report_problem("a word was dequeued while the model queue was empty");
      end
      check_data("core_data_o", core_data_o, model_q.pop_front());
      deq_left--;
    end
    if (acc) begin
      model_q.push_back(core_data_i);
      send_left--;
      sent_total++;
      phase_accepts++;
    end
    // word reaches the buffer one cycle after leaving the link register
    occ_model = occ_model + inflight - (deq ? 1 : 0);
    inflight = acc ? 1 : 0;
    drive_next();
  endtask

  task automatic wait_ready(input logic level, input int limit, input string what);
    int cycles;
    cycles = 0;
    step();
    while (ready_seen !== level) begin
      if (cycles >= limit) begin
        report_problem(what);
      end
      step();
      cycles++;
    end
  endtask

  task automatic hold_ready_low(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      step();
      check_bit("core_ready_o", ready_seen, 1'b0);
    end
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    while (send_left > 0 || model_q.size() != 0) begin
      if (cycles >= drain_limit_lp) begin
        report_problem("timeout: the word stream did not drain from the buffer");
      end
      step();
      cycles++;
    end
  endtask

  task automatic run_row(input stim_row_t row);
    send_mode     = row.send_mode;
    yumi_mode     = row.yumi_mode;
    send_left     = row.send_words;
    deq_left      = row.deq_words;
    phase_accepts = 0;
    case (row.phase)
      fill_ph: begin
        wait_ready(1'b0, 4 * fifo_depth_lp, "timeout: core_ready_o never fell while filling");
      end
      token_ph: begin
        wait_ready(1'b1, 200, "timeout: core_ready_o did not return after dequeues");
        wait_ready(1'b0, 200, "timeout: core_ready_o did not fall after returned credits");
      end
      default: begin
        drain();
      end
    endcase
    if (row.exp_accepts != 0) begin
      hold_ready_low(100);
      check_count("accepted words", link_pkg::credit_t'(phase_accepts),
                  link_pkg::credit_t'(row.exp_accepts));
    end
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    reset_i      = 1'b1;
    core_valid_i = 1'b0;
    core_data_i  = '0;
    core_yumi_i  = 1'b0;
    // outputs are unknown until the first reset edge
    for (int i = 0; i < 16; i++) begin
      step();
      if (i > 0) begin
        check_bit("core_ready_o", ready_seen, 1'b0);
      end
      checks_on = 1'b1;
    end
    reset_i <= 1'b0;
    // idle window after reset, then ready
    for (int i = 0; i < wait_cycles_lp; i++) begin
      step();
      check_bit("core_ready_o", ready_seen, 1'b0);
    end
    step();
    check_bit("core_ready_o", ready_seen, 1'b1);
    foreach (stim_table[r]) begin
      run_row(stim_table[r]);
    end
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* bench/link_kernel_props.sv */
/*
  link kernel properties
  invariants of the credit sender and the input fifo, bound into both.
  ports that a host block does not have are tied off in its bind
*/

`timescale 1ns/1ns

module link_kernel_props (
  input logic                    io_master_clk_i,
  input logic                    reset_i,
  input link_pkg::sender_state_t state_i,
  input logic                    ready_i,
  input logic                    token_i,
  input logic                    write_i,
  input logic                    full_i,
  input logic                    yumi_i,
  input logic                    valid_i
);

  // credits equal the depth, so a full buffer sees no link write
  assert property (@(posedge io_master_clk_i) disable iff (reset_i) full_i |-> !write_i)
    else $error("link write into a full input buffer");

  // ready only once the wait after reset is over
  assert property (@(posedge io_master_clk_i) disable iff (reset_i)
    ready_i |-> (state_i == link_pkg::run_s))
    else $error("core_ready_o high outside run_s");

  // token is a single-cycle pulse
  assert property (@(posedge io_master_clk_i) disable iff (reset_i) token_i |=> !token_i)
    else $error("token held high for more than one cycle");

  // core removes only a presented word
  assert property (@(posedge io_master_clk_i) disable iff (reset_i) yumi_i |-> valid_i)
    else $error("core_yumi_i without core_valid_o");

endmodule

bind credit_sender link_kernel_props sender_props (
  .io_master_clk_i(io_master_clk_i),
  .reset_i        (reset_i),
  .state_i        (state_r),
  .ready_i        (core_ready_o),
  .token_i        (token_i),
  .write_i        (1'b0),
  .full_i         (1'b0),
  .yumi_i         (1'b0),
  .valid_i        (1'b1)
);

bind input_fifo link_kernel_props fifo_props (
  .io_master_clk_i(io_master_clk_i),
  .reset_i        (reset_i),
  .state_i        (link_pkg::run_s),
  .ready_i        (1'b0),
  .token_i        (1'b0),
  .write_i        (link_valid_i),
  .full_i         (count_r == link_pkg::ptr_t'(depth_lp)),
  .yumi_i         (core_yumi_i),
  .valid_i        (core_valid_o)
);

/* verilog/link_kernel.sv */
/*
  link kernel
  one credit-based link channel on io_master_clk_i. the sender launches
  core words on a registered link into the input buffer, the core
  drains the buffer, and the token unit returns credits to the sender
*/

`timescale 1ns/1ns

module link_kernel #(
  parameter int lg_fifo_depth_p       = link_pkg::lg_fifo_depth_default_c,
  parameter int lg_decimation_p       = link_pkg::lg_decimation_default_c,
  parameter int lg_wait_after_reset_p = link_pkg::lg_wait_after_reset_default_c
) (
  input  logic                    io_master_clk_i,
  input  logic                    reset_i,

  // core in
  input  logic                    core_valid_i,
  input  link_pkg::channel_data_t core_data_i,
  output logic                    core_ready_o,

  // core out
  output logic                    core_valid_o,
  output link_pkg::channel_data_t core_data_o,
  input  logic                    core_yumi_i
);

  // registered link between sender and buffer
  logic                    link_valid;
  link_pkg::channel_data_t link_data;
  // credit return pulse
  logic                    token;

  // --------------------
  // producer
  // --------------------

  credit_sender #(
    .lg_fifo_depth_p      (lg_fifo_depth_p),
    .lg_decimation_p      (lg_decimation_p),
    .lg_wait_after_reset_p(lg_wait_after_reset_p)
  ) sender (
    .io_master_clk_i(io_master_clk_i),
    .reset_i        (reset_i),
    .core_valid_i   (core_valid_i),
    .core_data_i    (core_data_i),
    .core_ready_o   (core_ready_o),
    .token_i        (token),
    .link_valid_o   (link_valid),
    .link_data_o    (link_data)
  );

  // --------------------
  // buffer
  // --------------------

  // depth matches the sender's starting credits
  input_fifo #(
    .lg_fifo_depth_p(lg_fifo_depth_p)
  ) fifo (
    .io_master_clk_i(io_master_clk_i),
    .reset_i        (reset_i),
    .link_valid_i   (link_valid),
    .link_data_i    (link_data),
    .core_valid_o   (core_valid_o),
    .core_data_o    (core_data_o),
    .core_yumi_i    (core_yumi_i)
  );

  // --------------------
  // consumer
  // --------------------

  token_return #(
    .lg_decimation_p(lg_decimation_p)
  ) tokens (
    .io_master_clk_i(io_master_clk_i),
    .reset_i        (reset_i),
    .core_yumi_i    (core_yumi_i),
    .token_o        (token)
  );

endmodule

/* verilog/token_return.sv */
/*
  token return
  consumer-side credit return. counts words removed by the core and
  raises a registered one-cycle token for every 2^lg_decimation_p of
  them, each token standing for one decimated token clock edge
*/

`timescale 1ns/1ns

module token_return #(
  parameter int lg_decimation_p = link_pkg::lg_decimation_default_c
) (
  input  logic io_master_clk_i,
  input  logic reset_i,

  // one pulse per dequeued word
  input  logic core_yumi_i,

  // credit group returned to the sender
  output logic token_o
);

  logic [lg_decimation_p-1:0] deq_cnt_r;
  logic                       group_done;
  logic                       token_r;

  // --------------------
  // dequeue counter
  // --------------------

  // the dequeue that wraps the counter closes a group
  assign group_done = core_yumi_i & (&deq_cnt_r);

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      deq_cnt_r <= '0;
    end else if (core_yumi_i) begin
      deq_cnt_r <= deq_cnt_r + 1'b1;
    end
  end

  // --------------------
  // token pulse
  // --------------------

  // high for the one cycle after the closing dequeue
  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      token_r <= 1'b0;
    end else begin
      token_r <= group_done;
    end
  end

  assign token_o = token_r;

endmodule

/* verilog/input_fifo.sv */
/*
  input fifo
  circular buffer on the receive side of the link. every link valid
  pulse writes one word, the core sees the head word through valid/data
  and removes it with yumi. depth is 2^lg_fifo_depth_p, matching the
  sender's starting credits
*/

`timescale 1ns/1ns

module input_fifo #(
  parameter int lg_fifo_depth_p = link_pkg::lg_fifo_depth_default_c
) (
  input  logic                    io_master_clk_i,
  input  logic                    reset_i,

  // link in
  input  logic                    link_valid_i,
  input  link_pkg::channel_data_t link_data_i,

  // core side out
  output logic                    core_valid_o,
  output link_pkg::channel_data_t core_data_o,
  input  logic                    core_yumi_i
);

  localparam int depth_lp = 2 ** lg_fifo_depth_p;
  // last slot index, pointers wrap back to zero after it
  localparam link_pkg::ptr_t last_ptr_lp = link_pkg::ptr_t'(depth_lp - 1);

  link_pkg::channel_data_t mem_r [depth_lp];
  link_pkg::ptr_t          wr_ptr_r;
  link_pkg::ptr_t          rd_ptr_r;
  link_pkg::ptr_t          count_r;
  logic                    do_write;
  logic                    do_read;

  // advance a pointer by one slot with wrap
  function automatic link_pkg::ptr_t next_ptr(input link_pkg::ptr_t p);
    return (p == last_ptr_lp) ? link_pkg::ptr_t'(0) : link_pkg::ptr_t'(p + 1'b1);
  endfunction

  assign do_write = link_valid_i;
  // yumi only counts while a word is presented
  assign do_read  = core_yumi_i & core_valid_o;

  // --------------------
  // storage
  // --------------------

  always_ff @(posedge io_master_clk_i) begin
    if (do_write) begin
      mem_r[wr_ptr_r[lg_fifo_depth_p-1:0]] <= link_data_i;
    end
  end

  // --------------------
  // pointers, occupancy
  // --------------------

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (do_read) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      // write and read together keep the occupancy
      case ({do_write, do_read})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // head word is visible whenever the buffer holds anything
  assign core_valid_o = (count_r != '0);
  assign core_data_o  = mem_r[rd_ptr_r[lg_fifo_depth_p-1:0]];

endmodule

/* verilog/credit_sender.sv */
/*
  credit sender
  producer side of the link channel. idles for a fixed number of cycles
  after reset, then accepts core words while credits remain, spending one
  credit per word. each accepted word is launched on a registered link
  together with a one-cycle valid. every token pulse from the consumer
  returns a group of credits
*/

`timescale 1ns/1ns

module credit_sender #(
  parameter int lg_fifo_depth_p       = link_pkg::lg_fifo_depth_default_c,
  parameter int lg_decimation_p       = link_pkg::lg_decimation_default_c,
  parameter int lg_wait_after_reset_p = link_pkg::lg_wait_after_reset_default_c
) (
  input  logic                    io_master_clk_i,
  input  logic                    reset_i,

  // core side in
  input  logic                    core_valid_i,
  input  link_pkg::channel_data_t core_data_i,
  output logic                    core_ready_o,

  // returned credits, one pulse per group of dequeues
  input  logic                    token_i,

  // registered link toward the input buffer
  output logic                    link_valid_o,
  output link_pkg::channel_data_t link_data_o
);

  // credits at start of run equal the buffer depth
  localparam link_pkg::credit_t start_credits_lp = link_pkg::credit_t'(2 ** lg_fifo_depth_p);
  // credits returned by one token
  localparam link_pkg::credit_t token_credits_lp = link_pkg::credit_t'(2 ** lg_decimation_p);

  link_pkg::sender_state_t state_r;
  link_pkg::sender_state_t state_n;
  link_pkg::credit_t       credit_r;
  link_pkg::credit_t       credit_n;
  logic [lg_wait_after_reset_p-1:0] wait_cnt_r;
  logic                    wait_done;
  logic                    accept;
  logic                    link_valid_r;
  link_pkg::channel_data_t link_data_r;

  // --------------------
  // wait after reset
  // --------------------

  // counter saturates its last value on the final wait cycle
  assign wait_done = &wait_cnt_r;

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      wait_cnt_r <= '0;
    end else if (state_r == link_pkg::wait_s) begin
      wait_cnt_r <= wait_cnt_r + 1'b1;
    end
  end

  // --------------------
  // fsm and credits
  // --------------------

  // ready only in run_s with at least one credit left
  assign core_ready_o = (state_r == link_pkg::run_s) && (credit_r != '0);
  assign accept       = core_valid_i & core_ready_o;

  always_comb begin
    state_n  = state_r;
    credit_n = credit_r;
    case (state_r)
      link_pkg::wait_s: begin
        // leave wait_s after exactly 2^lg_wait_after_reset_p cycles
        if (wait_done) begin
          state_n  = link_pkg::run_s;
          credit_n = start_credits_lp;
        end
      end
      link_pkg::run_s: begin
        // a send and a token on the same edge combine
        credit_n = credit_r
                 - (accept  ? link_pkg::credit_t'(1) : link_pkg::credit_t'(0))
                 + (token_i ? token_credits_lp       : link_pkg::credit_t'(0));
      end
      default: begin
        state_n = link_pkg::wait_s;
      end
    endcase
  end

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      state_r  <= link_pkg::wait_s;
      credit_r <= '0;
    end else begin
      state_r  <= state_n;
      credit_r <= credit_n;
    end
  end

  // --------------------
  // link register
  // --------------------

  // valid is a pulse, one high cycle per accepted word
  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      link_valid_r <= 1'b0;
    end else begin
      link_valid_r <= accept;
    end
  end

  // data only moves on an accepted word
  always_ff @(posedge io_master_clk_i) begin
    if (accept) begin
      link_data_r <= core_data_i;
    end
  end

  assign link_valid_o = link_valid_r;
  assign link_data_o  = link_data_r;

endmodule

/* verilog/link_pkg.sv */
/*
  link package
  shared types and default constants for the credit-based link channel:
  the link word, the credit and pointer vectors, the sender state
  machine encoding and the parameter defaults used by the top level
*/

package link_pkg;

  // --------------------
  // data path
  // --------------------

  // width of one word on the link and on both core ports
  localparam int channel_width_c = 16;

  // one link word
  typedef logic [channel_width_c-1:0] channel_data_t;

  // --------------------
  // counters
  // --------------------

  // sender credit count, holds up to 2^7 starting credits
  typedef logic [7:0] credit_t;

  // buffer read/write pointers and occupancy
  typedef logic [7:0] ptr_t;

  // --------------------
  // sender fsm
  // --------------------

  // wait_s holds the sender idle after reset, run_s moves words
  typedef enum logic {
    wait_s = 1'b0,
    run_s  = 1'b1
  } sender_state_t;

  // defaults handed down by the top level
  // buffer depth 32, also the starting credit count
  localparam int lg_fifo_depth_default_c = 5;
  // one token per 8 dequeued words
  localparam int lg_decimation_default_c = 3;
  // 16 idle cycles after reset
  localparam int lg_wait_after_reset_default_c = 4;

endpackage
